// File: common/mipsPkg.sv
// shared constants and the instruction word type for the single-cycle core
// encodings follow the classic MIPS-I layout; only the supported subset is listed
package mipsPkg;

  // ==============================
  // sizes
  // ==============================
  localparam int xlen      = 32;
  localparam int regAddrW  = 5;
  localparam int dmemAddrW = 7;

  // jal return address target
  localparam logic [regAddrW-1:0] linkReg = 5'd31;

  // ==============================
  // opcode and funct encodings
  // ==============================
  localparam logic [5:0] opRtype = 6'b000000;
  localparam logic [5:0] opLw    = 6'b100011;
  localparam logic [5:0] opSw    = 6'b101011;
  localparam logic [5:0] opBeq   = 6'b000100;
  localparam logic [5:0] opJ     = 6'b000010;
  localparam logic [5:0] opJal   = 6'b000011;

  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr  = 6'b100101;
  localparam logic [5:0] fnSlt = 6'b101010;

  // main decode to alu control
  localparam logic [1:0] aluOpAdd   = 2'b00;
  localparam logic [1:0] aluOpSub   = 2'b01;
  localparam logic [1:0] aluOpFunct = 2'b10;

  // alu operation select
  localparam logic [3:0] aluAnd  = 4'b0000;
  localparam logic [3:0] aluOr   = 4'b0001;
  localparam logic [3:0] aluAdd  = 4'b0010;
  localparam logic [3:0] aluSub  = 4'b0110;
  localparam logic [3:0] aluSlt  = 4'b0111;
  localparam logic [3:0] aluNone = 4'b1111;

  // one instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [5:0]          opcode;
      logic [regAddrW-1:0] rs;
      logic [regAddrW-1:0] rt;
      logic [regAddrW-1:0] rd;
      logic [4:0]          shamt;
      logic [5:0]          funct;
    } rFields;
    struct packed {
      logic [5:0]          opcode;
      logic [regAddrW-1:0] rs;
      logic [regAddrW-1:0] rt;
      logic [15:0]         imm;
    } iFields;
    struct packed {
      logic [5:0]  opcode;
      logic [25:0] target;
    } jFields;
  } instrT;

endpackage

// File: mipsCore/pcUnit.sv
// program counter with sequential, branch and jump selection
// no delay slot; the branch offset arrives already sign-extended and shifted
`timescale 1ns/1ps

module pcUnit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [mipsPkg::xlen-1:0] branchOffset,
  input  logic [25:0]              jumpTarget,
  input  logic                     jump,
  input  logic                     branch,
  input  logic                     aluZero,
  output logic [mipsPkg::xlen-1:0] pc,
  output logic [mipsPkg::xlen-1:0] pcPlus8
);

  logic [mipsPkg::xlen-1:0] pcPlus4;
  logic [mipsPkg::xlen-1:0] branchAddr;
  logic [mipsPkg::xlen-1:0] jumpAddr;
  logic [mipsPkg::xlen-1:0] pcNext;

  assign pcPlus4    = pc + 32'd4;
  assign pcPlus8    = pc + 32'd8;
  assign branchAddr = pcPlus4 + branchOffset;
  // region bits come from the following instruction
  assign jumpAddr   = {pcPlus4[31:28], jumpTarget, 2'b00};

  // jump wins over a taken branch
  assign pcNext = jump ? jumpAddr :
                  (branch && aluZero) ? branchAddr : pcPlus4;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

// File: mipsCore/ctrlDecode.sv
// main control and alu control decode, purely combinational
// unknown opcodes and funct codes decode to a no-op
`timescale 1ns/1ps

module ctrlDecode (
  input  logic [5:0] opcode,
  input  logic [5:0] funct,
  output logic       regDst,
  output logic       aluSrc,
  output logic       memToReg,
  output logic       regWrite,
  output logic       memRead,
  output logic       memWrite,
  output logic       jump,
  output logic       branch,
  output logic       link,
  output logic [3:0] aluCtrl
);

  logic [1:0] aluOp;
  logic       regWriteMain;

  // ==============================
  // main decode
  // ==============================
  always_comb begin
    regDst       = 1'b0;
    aluSrc       = 1'b0;
    memToReg     = 1'b0;
    regWriteMain = 1'b0;
    memRead      = 1'b0;
    memWrite     = 1'b0;
    jump         = 1'b0;
    branch       = 1'b0;
    link         = 1'b0;
    // j, jal and unknown opcodes keep add so aluCtrl stays valid
    aluOp        = mipsPkg::aluOpAdd;
    case (opcode)
      mipsPkg::opRtype: begin
        regDst       = 1'b1;
        regWriteMain = 1'b1;
        aluOp        = mipsPkg::aluOpFunct;
      end
      mipsPkg::opLw: begin
        aluSrc       = 1'b1;
        memToReg     = 1'b1;
        regWriteMain = 1'b1;
        memRead      = 1'b1;
      end
      mipsPkg::opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      mipsPkg::opBeq: begin
        branch = 1'b1;
        aluOp  = mipsPkg::aluOpSub;
      end
      mipsPkg::opJ: begin
        jump = 1'b1;
      end
      mipsPkg::opJal: begin
        jump         = 1'b1;
        link         = 1'b1;
        regWriteMain = 1'b1;
      end
      default: begin
        // no-op
      end
    endcase
  end

  // ==============================
  // alu control
  // ==============================
  always_comb begin
    case (aluOp)
      mipsPkg::aluOpAdd: aluCtrl = mipsPkg::aluAdd;
      mipsPkg::aluOpSub: aluCtrl = mipsPkg::aluSub;
      mipsPkg::aluOpFunct: begin
        case (funct)
          mipsPkg::fnAdd: aluCtrl = mipsPkg::aluAdd;
          mipsPkg::fnSub: aluCtrl = mipsPkg::aluSub;
          mipsPkg::fnAnd: aluCtrl = mipsPkg::aluAnd;
          mipsPkg::fnOr:  aluCtrl = mipsPkg::aluOr;
          mipsPkg::fnSlt: aluCtrl = mipsPkg::aluSlt;
          default:        aluCtrl = mipsPkg::aluNone;
        endcase
      end
      default: aluCtrl = mipsPkg::aluNone;
    endcase
  end

  // bad funct suppresses the write
  assign regWrite = regWriteMain && (aluCtrl != mipsPkg::aluNone);

endmodule

// File: mipsCore/regFile.sv
// 31 general registers plus hard-wired zero
// two combinational read ports, one write port at the rising edge
`timescale 1ns/1ps

module regFile (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [mipsPkg::regAddrW-1:0] rdAddr1,
  input  logic [mipsPkg::regAddrW-1:0] rdAddr2,
  input  logic                         wrEn,
  input  logic [mipsPkg::regAddrW-1:0] wrAddr,
  input  logic [mipsPkg::xlen-1:0]     wrData,
  output logic [mipsPkg::xlen-1:0]     rdData1,
  output logic [mipsPkg::xlen-1:0]     rdData2
);

  // register 0 has no storage
  logic [mipsPkg::xlen-1:0] regs [1:31];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // zero index reads back 0
  assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
  assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

endmodule

// File: mipsCore/aluUnit.sv
// five-operation alu, slt compares signed
// aluNone and any other code give a zero result
`timescale 1ns/1ps

module aluUnit (
  input  logic [mipsPkg::xlen-1:0] a,
  input  logic [mipsPkg::xlen-1:0] b,
  input  logic [3:0]               aluCtrl,
  output logic [mipsPkg::xlen-1:0] result,
  output logic                     zero
);

  always_comb begin
    case (aluCtrl)
      mipsPkg::aluAdd: result = a + b;
      mipsPkg::aluSub: result = a - b;
      mipsPkg::aluAnd: result = a & b;
      mipsPkg::aluOr:  result = a | b;
      // signed less-than, one bit wide
      mipsPkg::aluSlt: result = {31'd0, ($signed(a) < $signed(b))};
      default:         result = '0;
    endcase
  end

  // beq equality test via the subtract result
  assign zero = (result == '0);

endmodule

// File: mipsCore/mipsCore.sv
// single-cycle core: fetch, decode, execute, register file and memory in one cycle
// instr must follow instrAddr before the next rising edge; the core never stalls
`timescale 1ns/1ps

module mipsCore (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [mipsPkg::xlen-1:0]      instr,
  output logic [mipsPkg::xlen-1:0]      instrAddr,
  input  logic [mipsPkg::xlen-1:0]      dmemRData,
  output logic [mipsPkg::dmemAddrW-1:0] dmemAddr,
  output logic [mipsPkg::xlen-1:0]      dmemWData,
  output logic                          dmemCen,
  output logic                          dmemWen,
  output logic                          wbEn,
  output logic [mipsPkg::regAddrW-1:0]  wbAddr,
  output logic [mipsPkg::xlen-1:0]      wbData
);

  mipsPkg::instrT ir;

  logic [mipsPkg::xlen-1:0]     immExt;
  logic [mipsPkg::xlen-1:0]     branchOffset;
  logic [mipsPkg::xlen-1:0]     pc;
  logic [mipsPkg::xlen-1:0]     pcPlus8;
  logic [mipsPkg::xlen-1:0]     rdData1;
  logic [mipsPkg::xlen-1:0]     rdData2;
  logic [mipsPkg::xlen-1:0]     aluB;
  logic [mipsPkg::xlen-1:0]     aluResult;
  logic [mipsPkg::xlen-1:0]     wrData;
  logic [mipsPkg::regAddrW-1:0] wrAddr;
  logic [3:0]                   aluCtrl;
  logic                         aluZero;
  logic                         regDst;
  logic                         aluSrc;
  logic                         memToReg;
  logic                         regWrite;
  logic                         memRead;
  logic                         memWrite;
  logic                         jump;
  logic                         branch;
  logic                         link;

  // ==============================
  // fields and immediates
  // ==============================
  assign ir           = instr;
  assign immExt       = {{16{ir.iFields.imm[15]}}, ir.iFields.imm};
  // word offset to byte offset
  assign branchOffset = {immExt[29:0], 2'b00};

  // ==============================
  // stages
  // ==============================
  pcUnit i_pcUnit (
    .clk          (clk),
    .rst          (rst),
    .branchOffset (branchOffset),
    .jumpTarget   (ir.jFields.target),
    .jump         (jump),
    .branch       (branch),
    .aluZero      (aluZero),
    .pc           (pc),
    .pcPlus8      (pcPlus8)
  );

  ctrlDecode i_ctrlDecode (
    .opcode   (ir.rFields.opcode),
    .funct    (ir.rFields.funct),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .memToReg (memToReg),
    .regWrite (regWrite),
    .memRead  (memRead),
    .memWrite (memWrite),
    .jump     (jump),
    .branch   (branch),
    .link     (link),
    .aluCtrl  (aluCtrl)
  );

  regFile i_regFile (
    .clk     (clk),
    .rst     (rst),
    .rdAddr1 (ir.rFields.rs),
    .rdAddr2 (ir.rFields.rt),
    .wrEn    (regWrite),
    .wrAddr  (wrAddr),
    .wrData  (wrData),
    .rdData1 (rdData1),
    .rdData2 (rdData2)
  );

  aluUnit i_aluUnit (
    .a       (rdData1),
    .b       (aluB),
    .aluCtrl (aluCtrl),
    .result  (aluResult),
    .zero    (aluZero)
  );

  // ==============================
  // datapath muxes
  // ==============================
  // destination: jal link, rd for r-type, else rt
  assign wrAddr = link   ? mipsPkg::linkReg :
                  regDst ? ir.rFields.rd : ir.rFields.rt;
  assign aluB   = aluSrc ? immExt : rdData2;
  assign wrData = link     ? pcPlus8 :
                  memToReg ? dmemRData : aluResult;

  // data memory, word addressed, wraps at 128 words
  assign dmemAddr  = aluResult[8:2];
  assign dmemWData = rdData2;
  assign dmemCen   = ~(memRead | memWrite);
  assign dmemWen   = ~memWrite;

  // retirement port
  assign instrAddr = pc;
  assign wbEn      = regWrite && (wrAddr != '0);
  assign wbAddr    = wrAddr;
  assign wbData    = wrData;

endmodule

// File: rtl/dataRam.sv
// 128-word data memory, contents undefined until written
// enables active low; read data is 0 while the chip is disabled
`timescale 1ns/1ps

module dataRam (
  input  logic                          clk,
  input  logic [mipsPkg::dmemAddrW-1:0] dmemAddr,
  input  logic [mipsPkg::xlen-1:0]      dmemWData,
  input  logic                          dmemCen,
  input  logic                          dmemWen,
  output logic [mipsPkg::xlen-1:0]      dmemRData
);

  logic [mipsPkg::xlen-1:0] mem [0:(1 << mipsPkg::dmemAddrW)-1];

  // write needs both enables low
  always_ff @(posedge clk) begin
    if (!dmemCen && !dmemWen) begin
      mem[dmemAddr] <= dmemWData;
    end
  end

  // combinational read gives same-cycle load data
  assign dmemRData = dmemCen ? '0 : mem[dmemAddr];

endmodule

// File: rtl/mipsSystem.sv
// processor subsystem top: core plus private data RAM
// instruction memory lives outside; instr must track instrAddr within the cycle
`timescale 1ns/1ps

module mipsSystem (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [mipsPkg::xlen-1:0]     instr,
  output logic [mipsPkg::xlen-1:0]     instrAddr,
  output logic                         wbEn,
  output logic [mipsPkg::regAddrW-1:0] wbAddr,
  output logic [mipsPkg::xlen-1:0]     wbData
);

  // core to data ram
  logic [mipsPkg::dmemAddrW-1:0] dmemAddr;
  logic [mipsPkg::xlen-1:0]      dmemWData;
  logic [mipsPkg::xlen-1:0]      dmemRData;
  logic                          dmemCen;
  logic                          dmemWen;

  mipsCore i_mipsCore (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .instrAddr (instrAddr),
    .dmemRData (dmemRData),
    .dmemAddr  (dmemAddr),
    .dmemWData (dmemWData),
    .dmemCen   (dmemCen),
    .dmemWen   (dmemWen),
    .wbEn      (wbEn),
    .wbAddr    (wbAddr),
    .wbData    (wbData)
  );

  dataRam i_dataRam (
    .clk       (clk),
    .dmemAddr  (dmemAddr),
    .dmemWData (dmemWData),
    .dmemCen   (dmemCen),
    .dmemWen   (dmemWen),
    .dmemRData (dmemRData)
  );

endmodule

// File: dv/mipsSystem_asserts.sv
// concurrent checks bound into every mipsCore instance
// sampled at the rising clock edge
`timescale 1ns/1ps

module mipsSystem_asserts (
  input logic        clk,
  input logic        rst,
  input logic [31:0] instrAddr,
  input logic        wbEn,
  input logic [4:0]  wbAddr,
  input logic        dmemCen,
  input logic        dmemWen
);

  // pc word alignment
  pcAligned: assert property (@(posedge clk) disable iff (!rst) instrAddr[1:0] == 2'b00)
    else $error("pc not word aligned: %h", instrAddr);

  noZeroWrite: assert property (@(posedge clk) disable iff (!rst) wbEn |-> wbAddr != 5'd0)
    else $error("write strobe with register 0 as destination");

  // store needs the chip enabled
  wenNeedsCen: assert property (@(posedge clk) disable iff (!rst) !dmemWen |-> !dmemCen)
    else $error("write enable low while chip enable high");

  idleInReset: assert property (@(posedge clk) !rst |-> (dmemCen && dmemWen))
    else $error("memory enables active during reset");

endmodule

bind mipsCore mipsSystem_asserts i_mipsSystem_asserts (
  .clk       (clk),
  .rst       (rst),
  .instrAddr (instrAddr),
  .wbEn      (wbEn),
  .wbAddr    (wbAddr),
  .dmemCen   (dmemCen),
  .dmemWen   (dmemWen)
);

// File: dv/tbMipsSystem.sv
// testbench for mipsSystem; acts as the instruction ROM, indexed modulo the program length
// the data RAM is not reset, so every program writes a word before it loads it
`timescale 1ns/1ps

module tbMipsSystem;

  logic        clk = 1'b0;
  logic        rst = 1'b0;
  logic [31:0] instr = '0;
  logic [31:0] instrAddr;
  logic        wbEn;
  logic [4:0]  wbAddr;
  logic [31:0] wbData;

  logic [31:0] prog [0:255];
  logic [31:0] progLen = 32'd1;
  logic [31:0] seed = 32'ha960_8407;
  logic        holdZero = 1'b1;
  logic        checking = 1'b0;
  int          stepCount, stepLimit, errCount, testsRun, testsFailed;
  string       testName;
  // architectural model
  logic [31:0] mPc, mReg [0:31], mMem [0:127];
  // one step of expected results
  logic [31:0] ins, eWbData, ePcNext, eMemData;
  logic [4:0]  eWbAddr;
  logic [6:0]  eMemIdx;
  logic        eWbEn, eMemWe;

  mipsSystem i_mipsSystem (.clk(clk), .rst(rst), .instr(instr), .instrAddr(instrAddr),
                           .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData));

  always #4 clk = ~clk;

  // ==============================
  // stimulus helpers
  // ==============================
  function automatic logic [31:0] lcgNext();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] mkR(input logic [4:0] rs, rt, rd, input logic [5:0] fn);
    mipsPkg::instrT w;
    w = '0;
    w.rFields.rs = rs;
    w.rFields.rt = rt;
    w.rFields.rd = rd;
    w.rFields.funct = fn;
    return w;
  endfunction

  function automatic logic [31:0] mkI(input logic [5:0] op, input logic [4:0] rs, rt,
                                      input logic [15:0] imm);
    mipsPkg::instrT w;
    w.iFields.opcode = op;
    w.iFields.rs = rs;
    w.iFields.rt = rt;
    w.iFields.imm = imm;
    return w;
  endfunction

  function automatic logic [31:0] mkJ(input logic [5:0] op, input logic [25:0] target);
    mipsPkg::instrT w;
    w.jFields.opcode = op;
    w.jFields.target = target;
    return w;
  endfunction

  // ==============================
  // reference model
  // ==============================
  function automatic void refStep(input logic [31:0] iw, input logic [31:0] pcIn,
      output logic wEn, output logic [4:0] wAddr, output logic [31:0] wData,
      output logic [31:0] pcNext, output logic mWe, output logic [6:0] mIdx,
      output logic [31:0] mData);
    logic [31:0] a, b, sImm, pc4, addr;
    logic        wr;
    a = mReg[iw[25:21]];
    b = mReg[iw[20:16]];
    sImm = {{16{iw[15]}}, iw[15:0]};
    pc4 = pcIn + 32'd4;
    addr = a + sImm;
    pcNext = pc4;
    wr = 1'b0;
    wAddr = iw[20:16];
    wData = '0;
    mWe = 1'b0;
    mIdx = addr[8:2];
    mData = b;
    case (iw[31:26])
      6'b000000: begin
        wr = 1'b1;
        wAddr = iw[15:11];
        case (iw[5:0])
          6'h20: wData = a + b;
          6'h22: wData = a - b;
          6'h24: wData = a & b;
          6'h25: wData = a | b;
          6'h2a: wData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: wr = 1'b0;
        endcase
      end
      6'b100011: begin
        wr = 1'b1;
        wData = mMem[mIdx];
      end
      6'b101011: mWe = 1'b1;
      6'b000100: if (a == b) pcNext = pc4 + (sImm << 2);
      6'b000010: pcNext = {pc4[31:28], iw[25:0], 2'b00};
      6'b000011: begin
        pcNext = {pc4[31:28], iw[25:0], 2'b00};
        wr = 1'b1;
        wAddr = 5'd31;
        wData = pcIn + 32'd8;
      end
      default: ;
    endcase
    wEn = wr && (wAddr != 5'd0);
  endfunction

  // ROM driver drives zero while held
  always @(negedge clk) begin
    instr = holdZero ? '0 : prog[(instrAddr >> 2) % progLen];
  end

  // ==============================
  // comparison 1 ns before the rising edge
  // ==============================
  always @(negedge clk) begin
    if (checking) begin
      #3;
      ins = prog[(mPc >> 2) % progLen];
      refStep(ins, mPc, eWbEn, eWbAddr, eWbData, ePcNext, eMemWe, eMemIdx, eMemData);
      assert (instrAddr === mPc) else begin
        $display("Mismatch %s instrAddr expected %h actual %h", testName, mPc, instrAddr);
        errCount++;
      end
      assert (wbEn === eWbEn) else begin
        $display("Mismatch %s wbEn expected %b actual %b", testName, eWbEn, wbEn);
        errCount++;
      end
      if (eWbEn) begin
        assert (wbAddr === eWbAddr && wbData === eWbData) else begin
          $display("Mismatch %s wb expected r%0d=%h actual r%0d=%h", testName, eWbAddr,
                   eWbData, wbAddr, wbData);
          errCount++;
        end
        mReg[eWbAddr] = eWbData;
      end
      if (eMemWe) mMem[eMemIdx] = eMemData;
      mPc = ePcNext;
      stepCount++;
      if (stepCount >= stepLimit) checking = 1'b0;
    end
  end

  task automatic runTest(input string name, input int nSteps);
    int errBefore, guard;
    errBefore = errCount;
    testName = name;
    @(negedge clk);
    rst = 1'b0;
    for (int c = 0; c < 7; c++) @(negedge clk);
    mPc = '0;
    for (int r = 0; r < 32; r++) mReg[r] = '0;
    stepCount = 0;
    stepLimit = nSteps;
    @(posedge clk);
    holdZero = 1'b0;
    checking = 1'b1;
    @(negedge clk);
    rst = 1'b1;
    guard = 0;
    while (checking && guard < nSteps + 20) begin
      @(posedge clk);
      guard++;
    end
    holdZero = 1'b1;
    if (checking) begin
      checking = 1'b0;
      errCount++;
      $display("test %s timed out before finishing its steps", name);
    end
    testsRun++;
    if (errCount != errBefore) testsFailed++;
    $display("test %s: %0d errors", name, errCount - errBefore);
  endtask

  initial begin
    logic [31:0] r;
    // jal seeds r31 with 8 and operands go through memory
    prog[0] = mkJ(mipsPkg::opJal, 26'd1);
    prog[1] = mkR(0, 31, 1, mipsPkg::fnSub);
    prog[2] = mkR(31, 31, 2, mipsPkg::fnAdd);
    prog[3] = mkI(mipsPkg::opSw, 0, 1, 16'd0);
    prog[4] = mkI(mipsPkg::opSw, 0, 2, 16'd4);
    prog[5] = mkI(mipsPkg::opLw, 0, 3, 16'd0);
    prog[6] = mkI(mipsPkg::opLw, 0, 4, 16'd4);
    prog[7] = mkR(3, 4, 5, mipsPkg::fnAdd);
    prog[8] = mkR(3, 4, 6, mipsPkg::fnSub);
    prog[9] = mkR(3, 4, 7, mipsPkg::fnAnd);
    prog[10] = mkR(3, 4, 8, mipsPkg::fnOr);
    prog[11] = mkR(3, 4, 9, mipsPkg::fnSlt);
    prog[12] = mkR(4, 3, 10, mipsPkg::fnSlt);
    progLen = 13;
    runTest("aluOps", 13);
    // offsets 0x200 and -4 wrap onto words 0 and 127
    prog[3] = mkI(mipsPkg::opSw, 0, 1, 16'h0010);
    prog[4] = mkI(mipsPkg::opSw, 0, 31, 16'h0200);
    prog[5] = mkI(mipsPkg::opSw, 0, 2, 16'h0204);
    prog[6] = mkI(mipsPkg::opSw, 0, 1, 16'hfffc);
    prog[7] = mkI(mipsPkg::opLw, 0, 5, 16'd4);
    prog[8] = mkI(mipsPkg::opLw, 0, 6, 16'h0010);
    prog[9] = mkI(mipsPkg::opLw, 0, 7, 16'd0);
    prog[10] = mkI(mipsPkg::opLw, 0, 8, 16'h01fc);
    progLen = 11;
    runTest("loadStore", 11);
    // branch taken forward, then not taken, then a backward loop
    prog[1] = mkR(31, 0, 1, mipsPkg::fnAdd);
    prog[2] = mkI(mipsPkg::opBeq, 1, 31, 16'd1);
    prog[3] = mkR(31, 31, 2, mipsPkg::fnAdd);
    prog[4] = mkI(mipsPkg::opBeq, 1, 0, 16'd3);
    prog[5] = mkR(3, 31, 3, mipsPkg::fnAdd);
    prog[6] = mkI(mipsPkg::opBeq, 0, 0, 16'hfffe);
    progLen = 7;
    runTest("branch", 14);
    // jumpLink
    prog[0] = mkJ(mipsPkg::opJ, 26'd3);
    prog[1] = mkR(31, 31, 9, mipsPkg::fnAdd);
    prog[3] = mkJ(mipsPkg::opJal, 26'd6);
    prog[6] = mkR(31, 0, 1, mipsPkg::fnAdd);
    prog[7] = mkJ(mipsPkg::opJ, 26'd0);
    progLen = 8;
    runTest("jumpLink", 12);
    // zeroAndNop
    prog[0] = mkJ(mipsPkg::opJal, 26'd1);
    prog[1] = mkR(31, 31, 0, mipsPkg::fnAdd);
    prog[2] = mkI(mipsPkg::opSw, 0, 31, 16'd0);
    prog[3] = mkI(mipsPkg::opLw, 0, 0, 16'd0);
    // unknown opcode with nonzero rt and rd fields
    prog[4] = mkI(6'h3f, 31, 4, 16'h2020);
    prog[5] = mkR(31, 31, 5, 6'h3f);
    prog[6] = mkR(0, 0, 6, mipsPkg::fnAdd);
    prog[7] = mkR(0, 31, 7, mipsPkg::fnOr);
    progLen = 8;
    runTest("zeroAndNop", 8);
    // random program clears words 0..15 before 200 mixed instructions
    for (int i = 0; i < 16; i++) prog[i] = mkI(mipsPkg::opSw, 0, 0, 16'(i * 4));
    for (int i = 16; i < 216; i++) begin
      r = lcgNext();
      case (r[31:29])
        3'd0, 3'd1: prog[i] = mkR(r[4:0], r[9:5], r[14:10], (r[20:18] == 3'd0) ? 6'h20 :
                      (r[20:18] == 3'd1) ? 6'h22 : (r[20:18] == 3'd2) ? 6'h24 :
                      (r[20:18] == 3'd3) ? 6'h25 : (r[20:18] == 3'd4) ? 6'h2a : r[26:21]);
        3'd2: prog[i] = mkI(mipsPkg::opLw, 0, r[9:5], 16'(r[13:10] * 4));
        3'd3: prog[i] = mkI(mipsPkg::opSw, 0, r[9:5], 16'(r[13:10] * 4));
        3'd4: prog[i] = mkI(mipsPkg::opBeq, {2'b00, r[2:0]}, {2'b00, r[7:5]},
                            {{13{r[12]}}, r[12:10]});
        3'd5: prog[i] = mkJ(mipsPkg::opJ, 26'(r[15:0] % 216));
        3'd6: prog[i] = mkJ(mipsPkg::opJal, 26'(r[15:0] % 216));
        default: prog[i] = {r[0] ? 6'h3f : 6'h01, r[25:0]};
      endcase
    end
    progLen = 216;
    runTest("randomProgram", 216);
    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
    if (errCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
common/mipsPkg.sv
mipsCore/pcUnit.sv
mipsCore/ctrlDecode.sv
mipsCore/regFile.sv
mipsCore/aluUnit.sv
mipsCore/mipsCore.sv
rtl/dataRam.sv
rtl/mipsSystem.sv
dv/mipsSystem_asserts.sv
dv/tbMipsSystem.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tbMipsSystem -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
else
  exit 1
fi
